/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_top
FLIST     := flist.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FLIST))
GOLDEN    := issue_golden.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM) $(GOLDEN)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter
import ooo_pkg::*;
(
    input   logic                               clk,
    input   logic                               rst,

    // requests and payload from every slot
    input   logic       [NUM_RS_SLOTS-1:0]      req_i,
    input   phys_tag_t  [NUM_RS_SLOTS-1:0]      slot_pd_i,
    input   word_t      [NUM_RS_SLOTS-1:0]      slot_result_i,
    output  logic       [NUM_RS_SLOTS-1:0]      grant_o,

    // registered broadcast
    output  logic                               cdb_valid_o,
    output  phys_tag_t                          cdb_pd_o,
    output  word_t                              cdb_value_o
);

    phys_tag_t  sel_pd;
    word_t      sel_value;

    // fixed priority, slot 0 wins
    always_comb begin
        logic found;
        found     = 1'b0;
        grant_o   = '0;
        sel_pd    = '0;
        sel_value = '0;
        for (int i = 0; i < NUM_RS_SLOTS; i++) begin
            if (req_i[i] && !found) begin
                grant_o[i] = 1'b1;
                sel_pd     = slot_pd_i[i];
                sel_value  = slot_result_i[i];
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= |grant_o;    // low in any cycle without a winner
        end
    end

    always_ff @(posedge clk) begin
        if (|grant_o) begin
            cdb_pd_o    <= sel_pd;
            cdb_value_o <= sel_value;
        end
    end

endmodule : cdb_arbiter

/* dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage
import ooo_pkg::*;
(
    input   logic                       clk,
    input   logic                       rst,

    // renamed operation from the source
    input   logic                       dispatch_valid_i,
    input   alu_op_t                    dispatch_op_i,
    input   phys_tag_t                  dispatch_ps1_i,
    input   phys_tag_t                  dispatch_ps2_i,
    input   phys_tag_t                  dispatch_pd_i,
    output  logic                       dispatch_ready_o,

    // slot occupancy and load strobes
    input   logic   [NUM_RS_SLOTS-1:0]  slot_busy_i,
    output  logic   [NUM_RS_SLOTS-1:0]  slot_load_o,

    // operation handed to the loaded slot
    output  alu_op_t                    op_o,
    output  phys_tag_t                  ps1_o,
    output  phys_tag_t                  ps2_o,
    output  phys_tag_t                  pd_o,
    output  word_t                      src1_val_o,
    output  word_t                      src2_val_o,
    output  logic                       src1_ready_o,
    output  logic                       src2_ready_o,

    // registered broadcast, fed back
    input   logic                       cdb_valid_i,
    input   phys_tag_t                  cdb_pd_i,
    input   word_t                      cdb_value_i
);

    word_t                      rf_data [NUM_PHYS_REGS];
    logic   [NUM_PHYS_REGS-1:0] rf_ready;

    logic                       bypass1;
    logic                       bypass2;
    logic                       accept;
    logic   [NUM_RS_SLOTS-1:0]  free_onehot;

    // cdb hit on a source tag in the dispatch cycle
    assign bypass1 = cdb_valid_i && (cdb_pd_i == dispatch_ps1_i);
    assign bypass2 = cdb_valid_i && (cdb_pd_i == dispatch_ps2_i);

    assign src1_ready_o = rf_ready[dispatch_ps1_i] || bypass1;
    assign src2_ready_o = rf_ready[dispatch_ps2_i] || bypass2;
    assign src1_val_o   = bypass1 ? cdb_value_i : rf_data[dispatch_ps1_i];
    assign src2_val_o   = bypass2 ? cdb_value_i : rf_data[dispatch_ps2_i];

    // operation fields pass straight to the slot being loaded
    assign op_o  = dispatch_op_i;
    assign ps1_o = dispatch_ps1_i;
    assign ps2_o = dispatch_ps2_i;
    assign pd_o  = dispatch_pd_i;

    // lowest-numbered free slot
    always_comb begin
        logic found;
        found       = 1'b0;
        free_onehot = '0;
        for (int i = 0; i < NUM_RS_SLOTS; i++) begin
            if (!slot_busy_i[i] && !found) begin
                free_onehot[i] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    assign dispatch_ready_o = ~&slot_busy_i;          // any slot free
    assign accept           = dispatch_valid_i && dispatch_ready_o;
    assign slot_load_o      = accept ? free_onehot : '0;

    // physical register file, p starts out holding p
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PHYS_REGS; p++) begin
                rf_data[p]  <= word_t'(p);
                rf_ready[p] <= 1'b1;
            end
        end else begin
            if (cdb_valid_i) begin
                rf_data[cdb_pd_i]  <= cdb_value_i;        // write-back
                rf_ready[cdb_pd_i] <= 1'b1;
            end
            if (accept) begin
                rf_ready[dispatch_pd_i] <= 1'b0;          // result now in flight
            end
        end
    end

endmodule : dispatch_stage

/* flist.f */
ooo_pkg.sv
dispatch_stage.sv
rs_slot.sv
cdb_arbiter.sv
issue_top.sv
issue_chk.sv
tb_top.sv

/* issue_chk.sv */
`timescale 1ns/1ps

module issue_chk
import ooo_pkg::*;
(
    input   logic                       clk,
    input   logic                       rst,
    input   logic   [NUM_RS_SLOTS-1:0]  req_i,
    input   logic   [NUM_RS_SLOTS-1:0]  grant_i,
    input   logic                       cdb_valid_i
);

    // at most one winner per cycle
    grant_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(grant_i)
    ) else $error("cdb grant is not one-hot: %b", grant_i);

    grant_to_requester: assert property (
        @(posedge clk) disable iff (rst) ((grant_i & ~req_i) == '0)
    ) else $error("cdb grant %b given to a slot without request %b", grant_i, req_i);

    // sync reset clears the broadcast valid
    idle_after_reset: assert property (
        @(posedge clk) $past(rst) |-> !cdb_valid_i
    ) else $error("cdb valid high in the cycle after reset");

endmodule : issue_chk

/* issue_golden.txt */
// columns op ps1 ps2 pd expected in hex
// opcodes 0 add 1 sub 2 and 3 or 4 xor and register p starts out holding p
// independent operations
0 03 05 20 00000008
1 0a 04 21 00000006
2 0d 07 22 00000005
3 09 06 23 0000000f
4 0c 0a 24 00000006
1 02 09 25 fffffff9
0 1f 1e 26 0000003d
4 1f 00 27 0000001f
// short dependent chains
0 20 21 28 0000000e
4 28 23 29 00000001
3 29 22 2a 00000005
1 26 2a 2b 00000038
2 2b 27 2c 00000018
0 25 2c 2d 00000011
0 2d 2d 2e 00000022
// long chain burst
0 2e 01 2f 00000023
1 2f 03 30 00000020
4 30 11 31 00000031
0 31 31 32 00000062
3 32 07 33 00000067
2 33 1e 34 00000006
1 34 2f 35 ffffffe3
4 35 32 36 ffffff81
0 36 30 37 ffffffa1
1 37 35 38 ffffffbe
2 38 33 39 00000026
3 39 37 3a ffffffa7
4 3a 38 3b 00000019
0 3b 3b 3c 00000032
1 02 3c 3d ffffffd0
0 3d 39 3e fffffff6
4 3e 20 3f fffffffe

/* issue_top.sv */
`timescale 1ns/1ps

module issue_top
import ooo_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // renamed operation stream
    input   logic       dispatch_valid_i,
    input   alu_op_t    dispatch_op_i,
    input   phys_tag_t  dispatch_ps1_i,
    input   phys_tag_t  dispatch_ps2_i,
    input   phys_tag_t  dispatch_pd_i,
    output  logic       dispatch_ready_o,

    // common data bus
    output  logic       cdb_valid_o,
    output  phys_tag_t  cdb_pd_o,
    output  word_t      cdb_value_o
);

    logic       [NUM_RS_SLOTS-1:0]  slot_busy;
    logic       [NUM_RS_SLOTS-1:0]  slot_load;
    logic       [NUM_RS_SLOTS-1:0]  slot_req;
    logic       [NUM_RS_SLOTS-1:0]  slot_grant;
    phys_tag_t  [NUM_RS_SLOTS-1:0]  slot_pd;
    word_t      [NUM_RS_SLOTS-1:0]  slot_result;

    // operation as presented to the slot being loaded
    alu_op_t    ld_op;
    phys_tag_t  ld_ps1;
    phys_tag_t  ld_ps2;
    phys_tag_t  ld_pd;
    word_t      ld_src1_val;
    word_t      ld_src2_val;
    logic       ld_src1_ready;
    logic       ld_src2_ready;

    dispatch_stage dispatch_stage_i (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_ps1_i   (dispatch_ps1_i),
        .dispatch_ps2_i   (dispatch_ps2_i),
        .dispatch_pd_i    (dispatch_pd_i),
        .dispatch_ready_o (dispatch_ready_o),
        .slot_busy_i      (slot_busy),
        .slot_load_o      (slot_load),
        .op_o             (ld_op),
        .ps1_o            (ld_ps1),
        .ps2_o            (ld_ps2),
        .pd_o             (ld_pd),
        .src1_val_o       (ld_src1_val),
        .src2_val_o       (ld_src2_val),
        .src1_ready_o     (ld_src1_ready),
        .src2_ready_o     (ld_src2_ready),
        .cdb_valid_i      (cdb_valid_o),
        .cdb_pd_i         (cdb_pd_o),
        .cdb_value_i      (cdb_value_o)
    );

    // reservation-station window
    for (genvar i = 0; i < NUM_RS_SLOTS; i++) begin : g_slot
        rs_slot rs_slot_i (
            .clk          (clk),
            .rst          (rst),
            .load_i       (slot_load[i]),
            .op_i         (ld_op),
            .ps1_i        (ld_ps1),
            .ps2_i        (ld_ps2),
            .pd_i         (ld_pd),
            .src1_val_i   (ld_src1_val),
            .src2_val_i   (ld_src2_val),
            .src1_ready_i (ld_src1_ready),
            .src2_ready_i (ld_src2_ready),
            .cdb_valid_i  (cdb_valid_o),
            .cdb_pd_i     (cdb_pd_o),
            .cdb_value_i  (cdb_value_o),
            .grant_i      (slot_grant[i]),
            .busy_o       (slot_busy[i]),
            .req_o        (slot_req[i]),
            .pd_o         (slot_pd[i]),
            .result_o     (slot_result[i])
        );
    end

    cdb_arbiter cdb_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (slot_req),
        .slot_pd_i     (slot_pd),
        .slot_result_i (slot_result),
        .grant_o       (slot_grant),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_pd_o      (cdb_pd_o),
        .cdb_value_o   (cdb_value_o)
    );

endmodule : issue_top

/* ooo_pkg.sv */
package ooo_pkg;

    // datapath and tag widths
    localparam int XLEN          = 32;
    localparam int PHYS_REG_BITS = 6;
    localparam int NUM_PHYS_REGS = 64;

    // reservation-station window depth
    localparam int NUM_RS_SLOTS  = 4;

    typedef logic [XLEN-1:0]          word_t;     // operand or result
    typedef logic [PHYS_REG_BITS-1:0] phys_tag_t; // physical register tag
    typedef logic [2:0]               alu_op_t;   // alu opcode

    // alu opcodes, as encoded in the operation stream
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    // life of one reservation-station entry
    typedef enum logic [1:0] {
        SLOT_FREE,  // empty, can take an operation
        SLOT_WAIT,  // holding, at least one operand missing
        SLOT_READY  // operands complete, requesting the cdb
    } slot_state_t;

endpackage : ooo_pkg

/* rs_slot.sv */
`timescale 1ns/1ps

module rs_slot
import ooo_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // load from the dispatch stage
    input   logic       load_i,
    input   alu_op_t    op_i,
    input   phys_tag_t  ps1_i,
    input   phys_tag_t  ps2_i,
    input   phys_tag_t  pd_i,
    input   word_t      src1_val_i,
    input   word_t      src2_val_i,
    input   logic       src1_ready_i,
    input   logic       src2_ready_i,

    // broadcast snooped for wake-up
    input   logic       cdb_valid_i,
    input   phys_tag_t  cdb_pd_i,
    input   word_t      cdb_value_i,

    // bus request and grant
    input   logic       grant_i,
    output  logic       busy_o,
    output  logic       req_o,
    output  phys_tag_t  pd_o,
    output  word_t      result_o
);

    slot_state_t    state;

    alu_op_t        op_q;
    phys_tag_t      ps1_q;
    phys_tag_t      ps2_q;
    phys_tag_t      pd_q;
    word_t          val1_q;
    word_t          val2_q;
    logic           rdy1_q;
    logic           rdy2_q;

    logic           hit1;
    logic           hit2;

    // tag match on a still-missing operand
    assign hit1 = (state == SLOT_WAIT) && cdb_valid_i && !rdy1_q && (cdb_pd_i == ps1_q);
    assign hit2 = (state == SLOT_WAIT) && cdb_valid_i && !rdy2_q && (cdb_pd_i == ps2_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SLOT_FREE;
            rdy1_q <= 1'b0;
            rdy2_q <= 1'b0;
        end else begin
            case (state)
                SLOT_FREE: begin
                    if (load_i) begin
                        rdy1_q <= src1_ready_i;
                        rdy2_q <= src2_ready_i;
                        state  <= (src1_ready_i && src2_ready_i) ? SLOT_READY : SLOT_WAIT;
                    end
                end
                SLOT_WAIT: begin
                    if (hit1) rdy1_q <= 1'b1;
                    if (hit2) rdy2_q <= 1'b1;
                    if (rdy1_q && rdy2_q) state <= SLOT_READY;  // one edge after capture
                end
                SLOT_READY: begin
                    if (grant_i) state <= SLOT_FREE;            // broadcast goes out now
                end
                default: state <= SLOT_FREE;
            endcase
        end
    end

    // operation payload and captured operands
    always_ff @(posedge clk) begin
        if (load_i) begin
            op_q   <= op_i;
            ps1_q  <= ps1_i;
            ps2_q  <= ps2_i;
            pd_q   <= pd_i;
            val1_q <= src1_val_i;
            val2_q <= src2_val_i;
        end else begin
            if (hit1) val1_q <= cdb_value_i;
            if (hit2) val2_q <= cdb_value_i;
        end
    end

    always_comb begin
        case (op_q)
            ALU_ADD: result_o = val1_q + val2_q;
            ALU_SUB: result_o = val1_q - val2_q;
            ALU_AND: result_o = val1_q & val2_q;
            ALU_OR:  result_o = val1_q | val2_q;
            ALU_XOR: result_o = val1_q ^ val2_q;
            default: result_o = '0;
        endcase
    end

    assign busy_o = (state != SLOT_FREE);
    assign req_o  = (state == SLOT_READY);
    assign pd_o   = pd_q;

endmodule : rs_slot

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top
import ooo_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int NUM_OPS       = 32;      // operations in the golden file
    localparam int FIELDS        = 5;       // op ps1 ps2 pd expected
    localparam int CYCLES_PER_OP = 20;
    localparam int SPARE_CYCLES  = 100;

    logic       clk;
    logic       rst;
    logic       dispatch_valid;
    alu_op_t    dispatch_op;
    phys_tag_t  dispatch_ps1;
    phys_tag_t  dispatch_ps2;
    phys_tag_t  dispatch_pd;
    logic       dispatch_ready;
    logic       cdb_valid;
    phys_tag_t  cdb_pd;
    word_t      cdb_value;

    word_t                      golden_mem [NUM_OPS*FIELDS];
    word_t                      exp_val [NUM_PHYS_REGS];    // expected result by tag
    logic   [NUM_PHYS_REGS-1:0] pending;                    // accepted but not yet broadcast
    int                         outstanding;
    int                         accepted;
    int                         broadcasts;
    int                         seed;

    issue_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_op_i    (dispatch_op),
        .dispatch_ps1_i   (dispatch_ps1),
        .dispatch_ps2_i   (dispatch_ps2),
        .dispatch_pd_i    (dispatch_pd),
        .dispatch_ready_o (dispatch_ready),
        .cdb_valid_o      (cdb_valid),
        .cdb_pd_o         (cdb_pd),
        .cdb_value_o      (cdb_value)
    );

    bind cdb_arbiter issue_chk chk0 (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .grant_i     (grant_o),
        .cdb_valid_i (cdb_valid_o)
    );

    function automatic word_t golden_field(input int line, input int col);
        return golden_mem[line*FIELDS + col];
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // overall limit scaled by the number of operations
    initial begin
        #((RESET_CYCLES + NUM_OPS*CYCLES_PER_OP + SPARE_CYCLES) * CLK_PERIOD);
        abort_run($sformatf("timeout: only %0d of %0d results were broadcast on the CDB",
                            broadcasts, NUM_OPS));
    end

    // scoreboard sampled mid-cycle when everything has settled
    always @(negedge clk) begin
        if (!rst) begin
            if (cdb_valid) begin
                check_value($sformatf("tag p%0d outstanding on cdb", cdb_pd), 1, pending[cdb_pd]);
                check_value($sformatf("cdb_value_o for p%0d", cdb_pd), exp_val[cdb_pd], cdb_value);
                pending[cdb_pd] = 1'b0;
                outstanding     = outstanding - 1;
                broadcasts      = broadcasts + 1;
            end
            check_value("dispatch_ready_o", outstanding != NUM_RS_SLOTS, dispatch_ready);
            if (dispatch_valid && dispatch_ready) begin     // taken at the coming edge
                exp_val[dispatch_pd] = golden_field(accepted, 4);
                pending[dispatch_pd] = 1'b1;
                outstanding          = outstanding + 1;
                accepted             = accepted + 1;
            end
        end
    end

    initial begin
        int gap;
        seed           = 32'h8e93_c853;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = ALU_ADD;
        dispatch_ps1   = '0;
        dispatch_ps2   = '0;
        dispatch_pd    = '0;
        pending        = '0;
        outstanding    = 0;
        accepted       = 0;
        broadcasts     = 0;
        $readmemh("issue_golden.txt", golden_mem);
        if ($isunknown(golden_mem[NUM_OPS*FIELDS-1])) begin
            abort_run("golden file issue_golden.txt is missing or too short");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("cdb_valid_o after reset", 0, cdb_valid);
        check_value("dispatch_ready_o after reset", 1, dispatch_ready);
        @(posedge clk);
        #1;

        for (int i = 0; i < NUM_OPS; i++) begin
            gap = $unsigned($random(seed)) % 3;     // 0 to 2 idle cycles
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            dispatch_valid = 1'b1;
            dispatch_op    = alu_op_t'(golden_field(i, 0));
            dispatch_ps1   = phys_tag_t'(golden_field(i, 1));
            dispatch_ps2   = phys_tag_t'(golden_field(i, 2));
            dispatch_pd    = phys_tag_t'(golden_field(i, 3));
            @(posedge clk);
            while (accepted <= i) @(posedge clk);   // held steady while stalled
            #1;
            dispatch_valid = 1'b0;
        end

        while (broadcasts < NUM_OPS) @(posedge clk);
        repeat (8) @(posedge clk);                  // catch stray broadcasts
        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_top
